//--- regDatapath_macros.svh
// Data width, register count and special register index macros for the datapath slice
`ifndef REGDP_MACROS_SVH
`define REGDP_MACROS_SVH

// Datapath word width
`define REGDP_DATA_W 16

// Register index width, enough for sixteen entries
`define REGDP_ADDR_W 4

`define REGDP_NUM_REGS 16 // Entries in the register file

// Special registers at the top of the file
`define REGDP_DS_IDX 14 // Data Segment
`define REGDP_SP_IDX 15 // Stack Pointer

`endif

//--- regDatapathPkg.sv
// Opcode encoding and the packed structs passed between datapath stages
`include "regDatapath_macros.svh"

package regDatapathPkg;

  typedef logic [`REGDP_ADDR_W-1:0] regIdx_t;
  typedef logic [`REGDP_DATA_W-1:0] word_t;

  // Opcode sits in the top four bits of the instruction word
  // Codes above OP_MOVSP are illegal
  typedef enum logic [3:0] {
    OP_ADD   = 4'h0,
    OP_SUB   = 4'h1,
    OP_AND   = 4'h2,
    OP_OR    = 4'h3,
    OP_XOR   = 4'h4,
    OP_MOV   = 4'h5,
    OP_LDI   = 4'h6,
    OP_ADDDS = 4'h7, // Data Segment plus rs2
    OP_MOVSP = 4'h8  // Copy of the Stack Pointer
  } opcode_e;

  typedef struct packed {
    opcode_e opcode;
    regIdx_t rd;
    regIdx_t rs1;
    regIdx_t rs2;
  } instr_t;

  typedef struct packed {
    logic                         valid;
    opcode_e                      op;
    regIdx_t                      rd;
    regIdx_t                      rs1;
    regIdx_t                      rs2;
    logic [2*`REGDP_ADDR_W-1:0]   imm8;     // rs1 and rs2 side by side, for LDI
    logic                         dataReg;  // Port 1 reads the Data Segment
    logic                         stackReg; // Port 1 reads the Stack Pointer
    logic                         writeEn;
    logic                         illegal;
  } decodedOp_t;

  typedef struct packed {
    logic    valid;
    regIdx_t rd;
    word_t   data;
    logic    carry;
    logic    writeEn;
    logic    illegal;
  } aluOut_t;

  typedef struct packed {
    logic    valid;
    regIdx_t rd;
    word_t   data;
    logic    zero;
    logic    negative;
    logic    carry;
    logic    illegal;
  } result_t;

endpackage

//--- instrDecoder.sv
// Instruction register and decoder at the input side of the datapath
`timescale 1ns/1ps

module instrDecoder (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       instrValid,
  input  regDatapathPkg::instr_t     instr,
  output regDatapathPkg::decodedOp_t decOp
);

  import regDatapathPkg::*;

  decodedOp_t decNext;

  // Field split and control derivation for the incoming word
  always_comb begin
    decNext = '0; // An idle cycle carries a bubble
    if (instrValid) begin
      decNext.valid = 1'b1;
      decNext.op    = instr.opcode;
      decNext.rd    = instr.rd;
      decNext.rs1   = instr.rs1;
      decNext.rs2   = instr.rs2;
      decNext.imm8  = {instr.rs1, instr.rs2};

      case (instr.opcode)
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MOV, OP_LDI: begin
          decNext.writeEn = 1'b1;
        end
        OP_ADDDS: begin
          decNext.dataReg = 1'b1; // Base comes from the Data Segment
          decNext.writeEn = 1'b1;
        end
        OP_MOVSP: begin
          decNext.stackReg = 1'b1;
          decNext.writeEn  = 1'b1;
        end
        default: begin
          // Unknown code travels on so the output can flag it
          decNext.illegal = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decOp <= '0;
    end else begin
      decOp <= decNext;
    end
  end

  // Both special selects steer the same read port
  assert property (@(posedge clk) disable iff (!rstN)
    !(decOp.dataReg && decOp.stackReg))
    else $error("instrDecoder: dataReg and stackReg set together");

endmodule

//--- regFile16.sv
// Sixteen-entry register file with Data Segment and Stack Pointer read selection
`timescale 1ns/1ps
`include "regDatapath_macros.svh"

module regFile16 (
  input  logic                    clk,
  input  logic                    rstN,
  input  regDatapathPkg::regIdx_t rdAddr1,
  input  regDatapathPkg::regIdx_t rdAddr2,
  input  logic                    dataReg,
  input  logic                    stackReg,
  input  logic                    wrEn,
  input  regDatapathPkg::regIdx_t wrAddr,
  input  regDatapathPkg::word_t   wrData,
  output regDatapathPkg::word_t   readData1,
  output regDatapathPkg::word_t   readData2
);

  import regDatapathPkg::*;

  localparam regIdx_t DsIdx = regIdx_t'(`REGDP_DS_IDX);
  localparam regIdx_t SpIdx = regIdx_t'(`REGDP_SP_IDX);

  word_t regs [`REGDP_NUM_REGS];

  // Single write port, all entries cleared on reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Read ports are combinational
  // A write at an edge is visible to the instruction decoded on that same edge
  always_comb begin
    if (stackReg) begin
      readData1 = regs[SpIdx];
      readData2 = '0; // MOVSP adds nothing to the Stack Pointer
    end else begin
      if (dataReg) begin
        readData1 = regs[DsIdx];
      end else begin
        readData1 = regs[rdAddr1];
      end
      readData2 = regs[rdAddr2];
    end
  end

  // Once reset has held for a cycle the pipeline is empty
  assert property (@(posedge clk)
    (!rstN ##1 !rstN) |-> !wrEn)
    else $error("regFile16: write requested during reset");

endmodule

//--- aluUnit.sv
// Combinational ALU for the decoded operation, with carry and borrow
`timescale 1ns/1ps

module aluUnit (
  input  regDatapathPkg::decodedOp_t decOp,
  input  regDatapathPkg::word_t      readData1,
  input  regDatapathPkg::word_t      readData2,
  output regDatapathPkg::aluOut_t    aluRes
);

  import regDatapathPkg::*;

  localparam int DataW = $bits(word_t);

  logic [DataW:0] sumWide;  // Extra bit holds the carry
  logic [DataW:0] diffWide; // Extra bit holds the borrow

  assign sumWide  = {1'b0, readData1} + {1'b0, readData2};
  assign diffWide = {1'b0, readData1} - {1'b0, readData2};

  always_comb begin
    aluRes         = '0;
    aluRes.valid   = decOp.valid;
    aluRes.rd      = decOp.rd;
    aluRes.writeEn = decOp.writeEn;
    aluRes.illegal = decOp.illegal;

    case (decOp.op)
      OP_ADD, OP_ADDDS: begin
        aluRes.data  = sumWide[DataW-1:0];
        aluRes.carry = sumWide[DataW];
      end
      OP_SUB: begin
        aluRes.data  = diffWide[DataW-1:0];
        aluRes.carry = diffWide[DataW];
      end
      OP_AND:   aluRes.data = readData1 & readData2;
      OP_OR:    aluRes.data = readData1 | readData2;
      OP_XOR:   aluRes.data = readData1 ^ readData2;
      OP_MOV:   aluRes.data = readData1;
      OP_LDI:   aluRes.data = word_t'(decOp.imm8); // Zero-extended immediate
      OP_MOVSP: aluRes.data = sumWide[DataW-1:0]; // Port 2 is zero here
      default: begin
        aluRes.data = '0; // Illegal code gives no data
      end
    endcase
  end

endmodule

//--- resultStage.sv
// Writeback drive, flag generation and output register of the datapath
`timescale 1ns/1ps

module resultStage (
  input  logic                    clk,
  input  logic                    rstN,
  input  regDatapathPkg::aluOut_t aluRes,
  output logic                    wrEn,
  output regDatapathPkg::regIdx_t wrAddr,
  output regDatapathPkg::word_t   wrData,
  output regDatapathPkg::result_t result
);

  import regDatapathPkg::*;

  result_t resultNext;

  // Write lands in the register file on the same edge that loads result
  assign wrEn   = aluRes.valid && aluRes.writeEn && !aluRes.illegal;
  assign wrAddr = aluRes.rd;
  assign wrData = aluRes.data;

  always_comb begin
    resultNext         = '0;
    resultNext.valid   = aluRes.valid;
    resultNext.rd      = aluRes.rd;
    resultNext.illegal = aluRes.illegal;
    if (aluRes.valid && !aluRes.illegal) begin
      resultNext.data     = aluRes.data;
      resultNext.zero     = (aluRes.data == '0);
      resultNext.negative = aluRes.data[$bits(word_t)-1]; // Sign bit
      resultNext.carry    = aluRes.carry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      result <= '0;
    end else begin
      result <= resultNext;
    end
  end

  // Each register write is reported next cycle as a legal result for the same target
  assert property (@(posedge clk) disable iff (!rstN)
    wrEn |=> (result.valid && !result.illegal && result.rd == $past(wrAddr)))
    else $error("resultStage: writeback without matching legal result");

endmodule

//--- regDatapathTop.sv
// Top level of the datapath slice connecting decoder, register file, ALU and output stage
`timescale 1ns/1ps

module regDatapathTop (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    instrValid,
  input  regDatapathPkg::instr_t  instr,
  output regDatapathPkg::result_t result
);

  import regDatapathPkg::*;

  decodedOp_t decOp;
  word_t      readData1;
  word_t      readData2;
  aluOut_t    aluRes;
  logic       wrEn;
  regIdx_t    wrAddr;
  word_t      wrData;

  instrDecoder decoder0 (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .decOp      (decOp)
  );

  regFile16 regFile0 (
    .clk       (clk),
    .rstN      (rstN),
    .rdAddr1   (decOp.rs1),
    .rdAddr2   (decOp.rs2),
    .dataReg   (decOp.dataReg),
    .stackReg  (decOp.stackReg),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  aluUnit alu0 (
    .decOp     (decOp),
    .readData1 (readData1),
    .readData2 (readData2),
    .aluRes    (aluRes)
  );

  resultStage resultStage0 (
    .clk    (clk),
    .rstN   (rstN),
    .aluRes (aluRes),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .result (result)
  );

endmodule

//--- tbRegDatapath.sv
// Self-checking testbench for the datapath slice driven by the instruction data file
`timescale 1ns/1ps
`include "regDatapath_macros.svh"

module tbRegDatapath;

  import regDatapathPkg::*;

  localparam int NumEntries  = 45;
  localparam int NumCols     = 8; // instr valid rd data zero negative carry illegal
  localparam int LimitCycles = NumEntries * 4 + 100;

  typedef struct packed {
    result_t exp;
    int      issueCycle;
    int      entry;
    logic    isMove;  // Read-back move of an LDI value
    word_t   moveExp; // Immediate that the move should return
  } pending_t;

  logic    clk;
  logic    rstN;
  logic    instrValid;
  instr_t  instr;
  result_t result;

  logic [`REGDP_DATA_W-1:0] testData [NumEntries*NumCols];
  pending_t pendQ [$];
  int cycleCount   = 0;

  word_t loadedVal [`REGDP_NUM_REGS]; // Immediate last loaded by LDI, per register
  logic  loadedOk  [`REGDP_NUM_REGS]; // Register still holds that immediate

  regDatapathTop dut0 (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .result     (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic string describeResult(input result_t r);
    return $sformatf("valid=%b rd=%0d data=%h z=%b n=%b c=%b ill=%b",
                     r.valid, r.rd, r.data, r.zero, r.negative, r.carry, r.illegal);
  endfunction

  task automatic checkResult(input result_t got, input result_t exp, input int entry);
    if (got !== exp) begin
      abortRun($sformatf("FAILED at time %0t: entry %0d gave %s, expected %s",
                         $time, entry, describeResult(got), describeResult(exp)));
    end
  endtask

  task automatic checkWord(input word_t got, input word_t exp, input int entry);
    if (got !== exp) begin
      abortRun($sformatf("FAILED at time %0t: entry %0d read back %h, expected %h",
                         $time, entry, got, exp));
    end
  endtask

  // Expected result built from the columns of one entry
  function automatic pending_t makePending(input int entry, input int base);
    pending_t p;
    instr_t   word;
    word           = testData[base];
    p.exp.valid    = 1'b1;
    p.exp.rd       = regIdx_t'(testData[base+2]);
    p.exp.data     = testData[base+3];
    p.exp.zero     = testData[base+4][0];
    p.exp.negative = testData[base+5][0];
    p.exp.carry    = testData[base+6][0];
    p.exp.illegal  = testData[base+7][0];
    p.issueCycle   = cycleCount;
    p.entry        = entry;
    p.isMove       = (word.opcode == OP_MOV) && loadedOk[word.rs1];
    p.moveExp      = loadedVal[word.rs1];
    return p;
  endfunction

  // LDI zero-extends rs1 and rs2 as the immediate, any other legal op overwrites rd
  function automatic void noteWrite(input instr_t word);
    if (word.opcode == OP_LDI) begin
      loadedVal[word.rd] = word_t'({word.rs1, word.rs2});
      loadedOk[word.rd]  = 1'b1;
    end else if (word.opcode <= OP_MOVSP) begin
      loadedOk[word.rd] = 1'b0;
    end
  endfunction

  // Sampled on the falling edge, clear of the input changes
  always @(negedge clk) begin
    if (rstN) begin
      if (result.valid) begin
        if (pendQ.size() == 0) begin
          abortRun("Result valid while no instruction was outstanding");
        end else if (cycleCount != pendQ[0].issueCycle + 2) begin
          abortRun($sformatf("Result of entry %0d came at cycle %0d instead of %0d",
                             pendQ[0].entry, cycleCount, pendQ[0].issueCycle + 2));
        end else begin
          if (pendQ[0].isMove) begin
            checkWord(result.data, pendQ[0].moveExp, pendQ[0].entry);
          end
          checkResult(result, pendQ[0].exp, pendQ[0].entry);
          void'(pendQ.pop_front());
        end
      end else if (pendQ.size() != 0 && cycleCount >= pendQ[0].issueCycle + 2) begin
        abortRun($sformatf("Result of entry %0d missing at cycle %0d",
                           pendQ[0].entry, cycleCount));
      end
    end
  end

  initial begin
    int base;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    foreach (loadedOk[k]) begin
      loadedOk[k]  = 1'b0;
      loadedVal[k] = '0;
    end
    void'($urandom(1)); // Fixed seed for the idle gaps
    $readmemh("regDatapath_testdata.txt", testData);

    repeat (8) @(posedge clk);
    #1 rstN = 1'b1;
    repeat (4) @(posedge clk); // No strobe, result.valid must stay low

    for (int i = 0; i < NumEntries; i++) begin
      base = i * NumCols;
      @(posedge clk);
      #1;
      if (testData[base+1][0]) begin
        instrValid = 1'b1;
        instr      = testData[base];
        pendQ.push_back(makePending(i, base));
        noteWrite(testData[base]);
      end else begin
        instrValid = 1'b0;
        instr      = '0;
        repeat ($urandom % 3) @(posedge clk);
      end
    end
    @(posedge clk);
    #1 instrValid = 1'b0;
    instr = '0;

    while (pendQ.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk); // Nothing more may come out
    $display("TEST PASS");
    $finish;
  end

  // Four cycles per entry covers the longest idle gaps, plus reset and drain
  initial begin
    repeat (LimitCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles with %0d results pending",
             LimitCycles, pendQ.size());
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

endmodule

//--- regDatapath.f
+incdir+.
regDatapathPkg.sv
instrDecoder.sv
regFile16.sv
aluUnit.sv
resultStage.sv
regDatapathTop.sv
tbRegDatapath.sv

//--- Bender.yml
package:
  name: regDatapath

sources:
  - include_dirs:
      - .
    files:
      - regDatapathPkg.sv
      - instrDecoder.sv
      - regFile16.sv
      - aluUnit.sv
      - resultStage.sv
      - regDatapathTop.sv
      - target: test
        files:
          - tbRegDatapath.sv

//--- regDatapath_testdata.txt
// Columns are instr valid rd data zero negative carry illegal in hex
// An entry with valid 0 is an idle slot of one to three cycles
3001 1 0 0000 1 0 0 0 // Reads after reset, OR r0 r0 r1
3023 1 0 0000 1 0 0 0
3045 1 0 0000 1 0 0 0
3067 1 0 0000 1 0 0 0
3089 1 0 0000 1 0 0 0
30AB 1 0 0000 1 0 0 0
30CD 1 0 0000 1 0 0 0
30EF 1 0 0000 1 0 0 0
0000 0 0 0000 0 0 0 0
60FF 1 0 00FF 0 0 0 0 // LDI r0..r7
6101 1 1 0001 0 0 0 0
620F 1 2 000F 0 0 0 0
633C 1 3 003C 0 0 0 0
6400 1 4 0000 1 0 0 0
6555 1 5 0055 0 0 0 0
6620 1 6 0020 0 0 0 0
677E 1 7 007E 0 0 0 0
5800 1 8 00FF 0 0 0 0 // MOV r8..r15 from r0..r7
5910 1 9 0001 0 0 0 0
5A20 1 A 000F 0 0 0 0
5B30 1 B 003C 0 0 0 0
5C40 1 C 0000 1 0 0 0
5D50 1 D 0055 0 0 0 0
5E60 1 E 0020 0 0 0 0
5F70 1 F 007E 0 0 0 0
0189 1 1 0100 0 0 0 0 // ADD r1 r8 r9
23AB 1 3 000C 0 0 0 0 // AND
34DA 1 4 005F 0 0 0 0 // OR
45EF 1 5 005E 0 0 0 0 // XOR
46DD 1 6 0000 1 0 0 0 // XOR with itself
12C9 1 2 FFFF 0 1 1 0 // SUB with borrow
0729 1 7 0000 1 0 1 0 // Dependent ADD with carry out
0771 1 7 0100 0 0 0 0 // Dependent on the ADD before
1089 1 0 00FE 0 0 0 0 // SUB without borrow
7831 1 8 0120 0 0 0 0 // ADDDS, rs1 ignored
6EF0 1 E 00F0 0 0 0 0 // New Data Segment
7902 1 9 00EF 0 0 1 0 // ADDDS right after the load
8A12 1 A 007E 0 0 0 0 // MOVSP
5F20 1 F FFFF 0 1 0 0
8B22 1 B FFFF 0 1 0 0 // MOVSP, r2 not added
0000 0 0 0000 0 0 0 0
9123 1 1 0000 0 0 0 1 // Illegal codes
FFFF 1 F 0000 0 0 0 1
5C10 1 C 0100 0 0 0 0 // r1 unchanged
3DFC 1 D FFFF 0 1 0 0 // r15 unchanged
